// ==== logic/sd_reg_map_pkg.sv ====
package sd_reg_map_pkg;

	// APB word address
	typedef logic [1:0] reg_addr_t;

	////////////////////
	// register offsets
	////////////////////

	localparam reg_addr_t REG_CTRL   = 2'd0;
	localparam reg_addr_t REG_DATA   = 2'd1;
	localparam reg_addr_t REG_STATUS = 2'd2;
	localparam reg_addr_t REG_BURST  = 2'd3;

	////////////////////
	// bit positions
	////////////////////

	// control, cs level and 2-bit speed above it
	localparam int CTRL_CS_BIT    = 0;
	localparam int CTRL_SPEED_LSB = 1;

	// status flags
	localparam int STAT_CPU_BUSY_BIT = 0;
	localparam int STAT_DMA_BUSY_BIT = 1;

endpackage

// ==== logic/spi_link_pkg.sv ====
package spi_link_pkg;

	// one byte on the wire and on the APB data bus
	typedef logic [7:0] spi_byte_t;

	// sck period is 2**(code+1) fclk cycles
	typedef logic [1:0] spi_speed_t;

	// burst length, 1 to 255 bytes
	typedef logic [7:0] burst_len_t;

	////////////////////
	// link constants
	////////////////////

	localparam spi_byte_t SPI_FILL = 8'hFF;
	localparam int        SPI_BITS = 8;

	// bit counter, wraps after the last bit
	localparam int SPI_CNT_W = 3;

	// half period counter, up to 8 cycles
	localparam int         SPI_DIV_W      = 3;
	localparam spi_speed_t SPI_SPEED_INIT = 2'd3;

endpackage

// ==== logic/spi_regs.sv ====
`timescale 1ns/1ps

module spi_regs (
	input  logic                        fclk,
	input  logic                        rst,

	// apb slave, no wait states
	input  sd_reg_map_pkg::reg_addr_t   paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  spi_link_pkg::spi_byte_t     pwdata,
	output spi_link_pkg::spi_byte_t     prdata,
	output logic                        pslverr,

	// link control
	output logic                        sdcs_n,
	output spi_link_pkg::spi_speed_t    speed,

	// cpu byte requests to the shifter
	output logic                        cpu_req,
	output spi_link_pkg::spi_byte_t     cpu_tx,
	input  logic                        cpu_ack,
	input  logic                        cpu_done,
	input  spi_link_pkg::spi_byte_t     rx_byte,

	// burst engine
	output logic                        burst_go,
	output spi_link_pkg::burst_len_t    burst_len,
	input  logic                        dma_busy
);
	import sd_reg_map_pkg::*;
	import spi_link_pkg::*;

	logic      access;
	logic      wr_ok;
	logic      wr_ctrl;
	logic      wr_data;
	logic      wr_burst;
	logic      cpu_busy;
	spi_byte_t rx_q;
	spi_byte_t ctrl_rd;
	spi_byte_t stat_rd;

	////////////////////
	// decode
	////////////////////

	assign access = psel && penable;

	// status is read only, data only once the last byte is through
	assign pslverr = access && pwrite &&
		(paddr == REG_STATUS || (paddr == REG_DATA && cpu_busy));

	assign wr_ok    = access && pwrite && !pslverr;
	assign wr_ctrl  = wr_ok && paddr == REG_CTRL;
	assign wr_data  = wr_ok && paddr == REG_DATA;
	assign wr_burst = wr_ok && paddr == REG_BURST;

	////////////////////
	// read mux
	////////////////////

	always_comb begin
		ctrl_rd = '0;
		ctrl_rd[CTRL_CS_BIT] = sdcs_n;
		ctrl_rd[CTRL_SPEED_LSB +: $bits(spi_speed_t)] = speed;

		stat_rd = '0;
		stat_rd[STAT_CPU_BUSY_BIT] = cpu_busy;
		stat_rd[STAT_DMA_BUSY_BIT] = dma_busy;
	end

	always_comb begin
		case (paddr)
			REG_CTRL:   prdata = ctrl_rd;
			REG_DATA:   prdata = rx_q;
			REG_STATUS: prdata = stat_rd;
			default:    prdata = burst_len;
		endcase
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			sdcs_n    <= 1'b1;
			speed     <= SPI_SPEED_INIT;
			cpu_req   <= 1'b0;
			cpu_busy  <= 1'b0;
			burst_go  <= 1'b0;
			burst_len <= '0;
			rx_q      <= '0;
		end else begin
			burst_go <= wr_burst;

			if (wr_ctrl) begin
				sdcs_n <= pwdata[CTRL_CS_BIT];
				speed  <= pwdata[CTRL_SPEED_LSB +: $bits(spi_speed_t)];
			end

			if (wr_burst)
				burst_len <= pwdata;

			// req drops at the grant, busy holds until the byte is back
			if (wr_data) begin
				cpu_req  <= 1'b1;
				cpu_busy <= 1'b1;
			end else begin
				if (cpu_ack)
					cpu_req <= 1'b0;
				if (cpu_done)
					cpu_busy <= 1'b0;
			end

			if (cpu_done)
				rx_q <= rx_byte;
		end
	end

	// outgoing cpu byte
	always_ff @(posedge fclk) begin
		if (wr_data)
			cpu_tx <= pwdata;
	end

endmodule

// ==== logic/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter (
	input  logic                        fclk,
	input  logic                        rst,
	input  spi_link_pkg::spi_speed_t    speed,

	// requesters, cpu first
	input  logic                        cpu_req,
	input  spi_link_pkg::spi_byte_t     cpu_tx,
	input  logic                        dma_req,
	output logic                        cpu_ack,
	output logic                        dma_ack,
	output logic                        cpu_done,
	output logic                        dma_done,
	output spi_link_pkg::spi_byte_t     rx_byte,

	// sd card pins, mode 0
	output logic                        sdclk,
	output logic                        sddo,
	input  logic                        sddi
);
	import spi_link_pkg::*;

	logic                 busy;
	logic                 owner_cpu;
	logic                 done_q;
	logic                 tick;
	spi_speed_t           speed_q;
	logic [SPI_DIV_W-1:0] div_cnt;
	logic [SPI_DIV_W-1:0] div_last;
	logic [SPI_CNT_W-1:0] bit_cnt;
	spi_byte_t            tx_sr;
	spi_byte_t            rx_sr;

	////////////////////
	// grant
	////////////////////

	assign cpu_ack = !busy && cpu_req;
	assign dma_ack = !busy && dma_req && !cpu_req;

	assign cpu_done = done_q && owner_cpu;
	assign dma_done = done_q && !owner_cpu;

	////////////////////
	// sck divider
	////////////////////

	// half period is 2**speed cycles
	assign div_last = SPI_DIV_W'((1 << speed_q) - 1);
	assign tick     = busy && div_cnt == div_last;

	assign sddo    = tx_sr[SPI_BITS-1];
	assign rx_byte = rx_sr;

	always_ff @(posedge fclk) begin
		if (rst) begin
			busy    <= 1'b0;
			done_q  <= 1'b0;
			sdclk   <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			tx_sr   <= SPI_FILL;
		end else begin
			done_q <= 1'b0;

			if (cpu_ack || dma_ack) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				tx_sr   <= cpu_ack ? cpu_tx : SPI_FILL;
			end else if (busy) begin
				if (tick) begin
					div_cnt <= '0;
					sdclk   <= !sdclk;

					// falling edge moves out the next bit
					if (sdclk) begin
						tx_sr   <= {tx_sr[SPI_BITS-2:0], 1'b1};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == SPI_CNT_W'(SPI_BITS - 1)) begin
							busy   <= 1'b0;
							done_q <= 1'b1;
						end
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// owner and speed held for the whole byte
	always_ff @(posedge fclk) begin
		if (cpu_ack || dma_ack) begin
			owner_cpu <= cpu_ack;
			speed_q   <= speed;
		end

		// rising edge samples the card
		if (tick && !sdclk)
			rx_sr <= {rx_sr[SPI_BITS-2:0], sddi};
	end

endmodule

// ==== logic/spi_dma.sv ====
`timescale 1ns/1ps

module spi_dma (
	input  logic                        fclk,
	input  logic                        rst,

	// burst start from the register block
	input  logic                        burst_go,
	input  spi_link_pkg::burst_len_t    burst_len,
	output logic                        dma_busy,

	// shifter side
	output logic                        dma_req,
	input  logic                        dma_ack,
	input  logic                        dma_done,
	input  spi_link_pkg::spi_byte_t     rx_byte,

	// byte stream out
	output spi_link_pkg::spi_byte_t     dma_data,
	output logic                        dma_valid,
	input  logic                        dma_ready
);
	import spi_link_pkg::*;

	burst_len_t left_cnt;
	logic       pend;
	logic       take;
	logic       launch;

	assign take = dma_valid && dma_ready;

	// one byte in flight at most, and only with room to land it
	assign launch = dma_busy && !pend && left_cnt != '0 && (!dma_valid || take);

	always_ff @(posedge fclk) begin
		if (rst) begin
			dma_busy  <= 1'b0;
			dma_req   <= 1'b0;
			dma_valid <= 1'b0;
			pend      <= 1'b0;
			left_cnt  <= '0;
		end else begin
			if (burst_go && !dma_busy && burst_len != '0) begin
				dma_busy <= 1'b1;
				left_cnt <= burst_len;
			end else if (dma_busy && left_cnt == '0 && !pend && (!dma_valid || take)) begin
				dma_busy <= 1'b0;
			end

			if (launch) begin
				dma_req  <= 1'b1;
				pend     <= 1'b1;
				left_cnt <= left_cnt - 1'b1;
			end

			if (dma_ack)
				dma_req <= 1'b0;
			if (dma_done)
				pend <= 1'b0;

			// holding register
			if (dma_done)
				dma_valid <= 1'b1;
			else if (take)
				dma_valid <= 1'b0;
		end
	end

	always_ff @(posedge fclk) begin
		if (dma_done)
			dma_data <= rx_byte;
	end

endmodule

// ==== logic/sd_spi_top.sv ====
`timescale 1ns/1ps

module sd_spi_top (
	input  logic                        fclk,
	input  logic                        rst,

	// apb
	input  sd_reg_map_pkg::reg_addr_t   paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  spi_link_pkg::spi_byte_t     pwdata,
	output spi_link_pkg::spi_byte_t     prdata,
	output logic                        pslverr,

	// sd card
	output logic                        sdcs_n,
	output logic                        sdclk,
	output logic                        sddo,
	input  logic                        sddi,

	// read burst stream
	output spi_link_pkg::spi_byte_t     dma_data,
	output logic                        dma_valid,
	input  logic                        dma_ready
);
	import spi_link_pkg::*;

	spi_speed_t speed;
	spi_byte_t  cpu_tx;
	spi_byte_t  rx_byte;
	burst_len_t burst_len;
	logic       cpu_req;
	logic       cpu_ack;
	logic       cpu_done;
	logic       dma_req;
	logic       dma_ack;
	logic       dma_done;
	logic       dma_busy;
	logic       burst_go;

	spi_regs regs_i (
		.fclk      (fclk),
		.rst       (rst),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.sdcs_n    (sdcs_n),
		.speed     (speed),
		.cpu_req   (cpu_req),
		.cpu_tx    (cpu_tx),
		.cpu_ack   (cpu_ack),
		.cpu_done  (cpu_done),
		.rx_byte   (rx_byte),
		.burst_go  (burst_go),
		.burst_len (burst_len),
		.dma_busy  (dma_busy)
	);

	spi_shifter shifter_i (
		.fclk     (fclk),
		.rst      (rst),
		.speed    (speed),
		.cpu_req  (cpu_req),
		.cpu_tx   (cpu_tx),
		.dma_req  (dma_req),
		.cpu_ack  (cpu_ack),
		.dma_ack  (dma_ack),
		.cpu_done (cpu_done),
		.dma_done (dma_done),
		.rx_byte  (rx_byte),
		.sdclk    (sdclk),
		.sddo     (sddo),
		.sddi     (sddi)
	);

	spi_dma dma_i (
		.fclk      (fclk),
		.rst       (rst),
		.burst_go  (burst_go),
		.burst_len (burst_len),
		.dma_busy  (dma_busy),
		.dma_req   (dma_req),
		.dma_ack   (dma_ack),
		.dma_done  (dma_done),
		.rx_byte   (rx_byte),
		.dma_data  (dma_data),
		.dma_valid (dma_valid),
		.dma_ready (dma_ready)
	);

endmodule

// ==== tb/sd_spi_asserts.sv ====
`timescale 1ns/1ps

module sd_spi_asserts (
	input logic fclk,
	input logic rst,
	input logic busy,
	input logic cpu_ack,
	input logic dma_ack,
	input logic cpu_done,
	input logic dma_done,
	input logic sdclk
);
	logic granted;

	// open grant, from ack until its done pulse
	always_ff @(posedge fclk) begin
		if (rst)
			granted <= 1'b0;
		else if (cpu_ack || dma_ack)
			granted <= 1'b1;
		else if (cpu_done || dma_done)
			granted <= 1'b0;
	end

	// one owner at a time, and a new grant only once the last byte is done
	one_grant: assert property (@(posedge fclk) disable iff (rst)
		(cpu_ack || dma_ack) |->
			!(cpu_ack && dma_ack) && (!granted || cpu_done || dma_done))
		else $error("two grants at once, or a grant while a byte is in flight");

	done_after_ack: assert property (@(posedge fclk) disable iff (rst)
		(cpu_done || dma_done) |-> granted)
		else $error("done pulse with no grant before it");

	sck_idle_low: assert property (@(posedge fclk) disable iff (rst)
		!busy |-> !sdclk)
		else $error("sdclk high while the shifter is idle");

endmodule

bind spi_shifter sd_spi_asserts asserts_i (
	.fclk     (fclk),
	.rst      (rst),
	.busy     (busy),
	.cpu_ack  (cpu_ack),
	.dma_ack  (dma_ack),
	.cpu_done (cpu_done),
	.dma_done (dma_done),
	.sdclk    (sdclk)
);

// ==== tb/sd_spi_tb.sv ====
`timescale 1ns/1ps

module sd_spi_tb;
	import sd_reg_map_pkg::*;
	import spi_link_pkg::*;

	localparam logic [31:0] SEED = 32'h9bd60632;
	localparam int POLL_LIMIT = 2000;
	localparam int SCK_LIMIT  = 200;

	logic      fclk = 1'b0;
	logic      rst;
	reg_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	spi_byte_t pwdata;
	spi_byte_t prdata;
	logic      pslverr;
	logic      sdcs_n;
	logic      sdclk;
	logic      sddo;
	logic      sddi;
	spi_byte_t dma_data;
	logic      dma_valid;
	logic      dma_ready;

	logic [31:0] stim_state = SEED;
	logic [31:0] card_state = SEED;
	logic [31:0] sink_state = SEED;
	spi_byte_t   card_rx[$];
	int          fill_slots[$];
	spi_byte_t   cap_sr = '0;
	spi_byte_t   resp_sr;
	int          cap_cnt = 0;
	int          slot_rd = 0;
	int          stream_cnt = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          failed_tests = 0;
	int          test_err0 = 0;
	event        run_end;

	sd_spi_top dut_i (.*);

	always #5 fclk = ~fclk;

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// card response for transfer number idx
	function automatic spi_byte_t ref_resp(input int idx);
		logic [31:0] s;
		s = SEED;
		for (int i = 0; i <= idx; i++)
			s = lcg_next(s);
		return s[23:16];
	endfunction

	function automatic spi_byte_t rand_byte();
		stim_state = lcg_next(stim_state);
		return stim_state[31:24];
	endfunction

	function automatic spi_byte_t ctrl_word(input logic cs, input int code);
		return spi_byte_t'((code << CTRL_SPEED_LSB) | (int'(cs) << CTRL_CS_BIT));
	endfunction

	task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("mismatch %s: got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic test_end(input string name);
		tests++;
		if (errors == test_err0) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	// verdict after the last test or a timeout
	initial begin
		@(run_end);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	////////////////////
	// apb master
	////////////////////

	task automatic apb_cycle(input reg_addr_t addr, input logic wr, input spi_byte_t data,
		input logic exp_err, output spi_byte_t rd);
		@(posedge fclk);
		#1;
		paddr  = addr;
		pwdata = data;
		pwrite = wr;
		psel   = 1'b1;
		@(posedge fclk);
		#1;
		penable = 1'b1;
		@(negedge fclk);
		rd = prdata;
		check_flag("pslverr", pslverr, exp_err);
		@(posedge fclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input reg_addr_t addr, input spi_byte_t data, input logic exp_err);
		spi_byte_t unused;
		apb_cycle(addr, 1'b1, data, exp_err, unused);
	endtask

	task automatic apb_read(input reg_addr_t addr, output spi_byte_t rd);
		apb_cycle(addr, 1'b0, 8'h00, 1'b0, rd);
	endtask

	task automatic wait_status_low(input int bit_pos, input string what);
		spi_byte_t s;
		for (int n = 0; n < POLL_LIMIT; n++) begin
			apb_read(REG_STATUS, s);
			if (!s[bit_pos])
				return;
		end
		$display("timeout waiting for %s to clear", what);
		errors++;
		-> run_end;
		@(run_end);
	endtask

	// cycles between two rising sdclk edges
	task automatic measure_sck(output int period);
		logic prev;
		int   first;
		first = -1;
		prev  = sdclk;
		for (int n = 0; n < SCK_LIMIT; n++) begin
			@(negedge fclk);
			if (sdclk && !prev) begin
				if (first >= 0) begin
					period = n - first;
					return;
				end
				first = n;
			end
			prev = sdclk;
		end
		$display("timeout: sdclk did not rise twice");
		errors++;
		-> run_end;
		@(run_end);
	endtask

	// the cpu byte's slot on the card picks its response
	task automatic finish_cpu_byte(input spi_byte_t tx, input int base);
		spi_byte_t rd;
		int        slot;
		slot = -1;
		wait_status_low(STAT_CPU_BUSY_BIT, "CPU busy");
		for (int i = base; i < card_rx.size(); i++)
			if (card_rx[i] == tx)
				slot = i;
		if (slot < 0) begin
			$display("CPU byte %h never reached the card", tx);
			errors++;
		end else begin
			apb_read(REG_DATA, rd);
			check_byte("prdata", rd, ref_resp(slot));
		end
	endtask

	////////////////////
	// sd card model
	////////////////////

	always @(posedge sdclk) begin
		if (!sdcs_n) begin
			cap_sr = {cap_sr[6:0], sddo};
			cap_cnt++;
			if (cap_cnt == SPI_BITS) begin
				card_rx.push_back(cap_sr);
				if (cap_sr == SPI_FILL)
					fill_slots.push_back(card_rx.size() - 1);
				cap_cnt = 0;
			end
		end
	end

	initial begin
		card_state = lcg_next(card_state);
		resp_sr = card_state[23:16];
		sddi = resp_sr[7];
		forever begin
			@(negedge sdclk);
			#1;
			if (!sdcs_n) begin
				// next response byte once the last one is out
				if (cap_cnt == 0) begin
					card_state = lcg_next(card_state);
					resp_sr = card_state[23:16];
				end else begin
					resp_sr = {resp_sr[6:0], 1'b0};
				end
				sddi = resp_sr[7];
			end
		end
	end

	// stream sink with random back-pressure
	initial begin
		dma_ready = 1'b0;
		forever begin
			@(posedge fclk);
			#1;
			sink_state = lcg_next(sink_state);
			dma_ready = !rst && sink_state[30];
			@(negedge fclk);
			if (dma_valid && dma_ready) begin
				stream_cnt++;
				if (slot_rd >= fill_slots.size()) begin
					$display("stream byte %h arrived with no burst byte on the card", dma_data);
					errors++;
				end else begin
					check_byte("dma_data", dma_data, ref_resp(fill_slots[slot_rd]));
					slot_rd++;
				end
			end
		end
	end

	////////////////////
	// tests
	////////////////////

	initial begin
		spi_byte_t rd;
		spi_byte_t tx;
		int        base;
		int        n_burst;
		int        period;
		int        s0;

		rst     = 1'b1;
		paddr   = REG_CTRL;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		repeat (5) @(posedge fclk);
		#1;
		rst = 1'b0;

		check_flag("sdcs_n", sdcs_n, 1'b1);
		check_flag("dma_valid", dma_valid, 1'b0);
		apb_read(REG_CTRL, rd);
		check_byte("ctrl", rd, ctrl_word(1'b1, 3));
		apb_read(REG_STATUS, rd);
		check_byte("status", rd, 8'h00);
		test_end("reset state");

		// bit 7 clear keeps cpu bytes apart from fill bytes
		apb_write(REG_CTRL, ctrl_word(1'b0, 1), 1'b0);
		tx = rand_byte() & 8'h7F;
		base = card_rx.size();
		apb_write(REG_DATA, tx, 1'b0);
		finish_cpu_byte(tx, base);
		check_count("card bytes", card_rx.size() - base, 1);
		test_end("cpu exchange");

		for (int code = 0; code < 4; code++) begin
			apb_write(REG_CTRL, ctrl_word(1'b0, code), 1'b0);
			tx = rand_byte() & 8'h7F;
			base = card_rx.size();
			apb_write(REG_DATA, tx, 1'b0);
			measure_sck(period);
			check_count("sdclk period", period, 1 << (code + 1));
			finish_cpu_byte(tx, base);
		end
		apb_write(REG_CTRL, ctrl_word(1'b0, 1), 1'b0);
		test_end("speed");

		tx = rand_byte() & 8'h7F;
		base = card_rx.size();
		apb_write(REG_DATA, tx, 1'b0);
		apb_write(REG_DATA, tx ^ 8'h55, 1'b1);
		finish_cpu_byte(tx, base);
		check_count("card bytes", card_rx.size() - base, 1);
		apb_write(REG_STATUS, 8'h03, 1'b1);
		test_end("error response");

		base = card_rx.size();
		s0 = stream_cnt;
		n_burst = 8 + int'(rand_byte() & 8'h0F);
		apb_write(REG_BURST, spi_byte_t'(n_burst), 1'b0);
		apb_write(REG_BURST, 8'd5, 1'b0);
		wait_status_low(STAT_DMA_BUSY_BIT, "burst busy");
		check_count("stream bytes", stream_cnt - s0, n_burst);
		check_count("card bytes", card_rx.size() - base, n_burst);
		for (int i = base; i < card_rx.size(); i++)
			check_byte("card sddo", card_rx[i], SPI_FILL);
		apb_write(REG_BURST, 8'd0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			apb_read(REG_STATUS, rd);
			check_flag("status dma busy", rd[STAT_DMA_BUSY_BIT], 1'b0);
		end
		check_count("stream bytes", stream_cnt - s0, n_burst);
		test_end("burst");

		base = card_rx.size();
		s0 = stream_cnt;
		n_burst = 10;
		apb_write(REG_BURST, spi_byte_t'(n_burst), 1'b0);
		tx = rand_byte() & 8'h7F;
		apb_write(REG_DATA, tx, 1'b0);
		finish_cpu_byte(tx, base);
		wait_status_low(STAT_DMA_BUSY_BIT, "burst busy");
		check_count("stream bytes", stream_cnt - s0, n_burst);
		check_count("card bytes", card_rx.size() - base, n_burst + 1);
		check_count("unclaimed burst bytes", fill_slots.size() - slot_rd, 0);
		test_end("mixed traffic");

		-> run_end;
	end

endmodule

// ==== verilog.f ====
logic/sd_reg_map_pkg.sv
logic/spi_link_pkg.sv
logic/spi_regs.sv
logic/spi_shifter.sv
logic/spi_dma.sv
logic/sd_spi_top.sv
tb/sd_spi_asserts.sv
tb/sd_spi_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := sd_spi_tb
FILELIST   := verilog.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
